// File: common/a09Pkg.sv
`default_nettype none

package a09Pkg;

    // ------------------------------------------------------------------------
    // Widths and IR field sizes
    // ------------------------------------------------------------------------
    localparam int dataWidthP   = 16;   // Datapath width
    localparam int addrWidthP   = 8;    // 256 words
    localparam int regSelWidthP = 3;    // Eight registers
    localparam int absWidthP    = 9;    // Absolute field IR[8:0]
    localparam int relWidthP    = 10;   // Branch offset IR[9:0]

    // Flag bit positions
    localparam int flagZeroP  = 0;
    localparam int flagNegP   = 1;
    localparam int flagCarryP = 2;
    localparam int flagOvfP   = 3;

    typedef logic [dataWidthP-1:0]   word_t;
    typedef logic [regSelWidthP-1:0] regSel_t;
    typedef logic [3:0]              flags_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluPass             // A straight through
    } aluOp_t;

    // Upper nibble of the instruction word
    typedef enum logic [3:0] {
        opNop = 4'd0,
        opLdi = 4'd1,
        opLd  = 4'd2,
        opSt  = 4'd3,
        opAdd = 4'd4,
        opSub = 4'd5,
        opAnd = 4'd6,
        opOr  = 4'd7,
        opOut = 4'd8,
        opBne = 4'd9,
        opJpl = 4'd10,
        opRet = 4'd11,
        opHlt = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        sReset,
        sFetch,
        sDecode,
        sExecute,
        sWriteback,
        sHalt
    } seqState_t;

    typedef enum logic [1:0] {addrPc, addrAbs} addrSrc_t;
    typedef enum logic [1:0] {pcBranch, pcStack, pcAbs} pcSrc_t;
    typedef enum logic [1:0] {dataImm, dataMem, dataAlu} dataSrc_t;

endpackage

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int DataWidth = a09Pkg::dataWidthP
) (
    input  wire                 Clk,
    input  wire                 rstN,
    input  wire a09Pkg::aluOp_t aluOp,
    input  wire                 aluLd,
    input  wire                 flgLd,
    input  wire a09Pkg::word_t  a,
    input  wire a09Pkg::word_t  b,
    output a09Pkg::word_t       result,
    output a09Pkg::flags_t      flags
);

    logic [DataWidth:0] wide;       // Carry/borrow in the top bit
    a09Pkg::word_t      y;
    logic               ovf;
    a09Pkg::flags_t     flagsNext;

    always_comb begin
        ovf = 1'b0;
        case (aluOp)
            a09Pkg::aluAdd: begin
                wide = {1'b0, a} + {1'b0, b};
                ovf  = (a[DataWidth-1] == b[DataWidth-1]) && (wide[DataWidth-1] != a[DataWidth-1]);
            end
            a09Pkg::aluSub: begin
                wide = {1'b0, a} - {1'b0, b};
                ovf  = (a[DataWidth-1] != b[DataWidth-1]) && (wide[DataWidth-1] != a[DataWidth-1]);
            end
            a09Pkg::aluAnd: wide = {1'b0, a & b};
            a09Pkg::aluOr:  wide = {1'b0, a | b};
            default:        wide = {1'b0, a};
        endcase
    end

    assign y = wide[DataWidth-1:0];

    always_comb begin
        flagsNext                       = '0;
        flagsNext[a09Pkg::flagZeroP]    = (y == '0);
        flagsNext[a09Pkg::flagNegP]     = y[DataWidth-1];
        flagsNext[a09Pkg::flagCarryP]   = wide[DataWidth];
        flagsNext[a09Pkg::flagOvfP]     = ovf;
    end

    // Result and flag registers
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            result <= '0;
            flags  <= '0;
        end else begin
            if (aluLd) result <= y;
            if (flgLd) flags  <= flagsNext;
        end
    end

endmodule

`default_nettype wire

// File: design/memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory #(
    parameter int DataWidth = a09Pkg::dataWidthP,
    parameter int AddrWidth = a09Pkg::addrWidthP
) (
    input  wire                   Clk,
    input  wire                   memEn,
    input  wire                   memWr,
    input  wire a09Pkg::addrSrc_t addrSrc,
    input  wire a09Pkg::word_t    pc,
    input  wire a09Pkg::word_t    ir,
    input  wire a09Pkg::word_t    wrData,
    input  wire                   progWe,
    input  wire [AddrWidth-1:0]   progAddr,
    input  wire a09Pkg::word_t    progData,
    output a09Pkg::word_t         rdData
);

    logic [DataWidth-1:0] ram [2**AddrWidth];  // Program and data share it
    a09Pkg::word_t        absExt;
    logic [AddrWidth-1:0] addr;

    assign absExt = {{(DataWidth-a09Pkg::absWidthP){1'b0}}, ir[a09Pkg::absWidthP-1:0]};
    assign addr   = (addrSrc == a09Pkg::addrAbs) ? absExt[AddrWidth-1:0] : pc[AddrWidth-1:0];

    always_ff @(posedge Clk) begin
        if (progWe) begin
            ram[progAddr] <= progData;      // Loader port
        end else if (memEn && memWr) begin
            ram[addr] <= wrData;
        end
        if (memEn && !memWr) begin
            rdData <= ram[addr];            // Valid the cycle after memEn
        end
    end

    aLoadVsStore: assert property (@(posedge Clk) !(progWe && memWr));

endmodule

`default_nettype wire

// File: design/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
    parameter int DataWidth = a09Pkg::dataWidthP
) (
    input  wire                 Clk,
    input  wire                 rstN,
    input  wire                 pcInc,
    input  wire                 pcLd,
    input  wire a09Pkg::pcSrc_t pcSrc,
    input  wire                 stkLd,
    input  wire a09Pkg::word_t  ir,
    input  wire a09Pkg::word_t  src1Data,
    output a09Pkg::word_t       pc
);

    a09Pkg::word_t stack;           // One-entry link register
    a09Pkg::word_t relExt;
    a09Pkg::word_t absExt;
    a09Pkg::word_t branchTarget;
    a09Pkg::word_t nextPc;

    assign relExt = {{(DataWidth-a09Pkg::relWidthP){ir[a09Pkg::relWidthP-1]}},
                     ir[a09Pkg::relWidthP-1:0]};
    assign absExt = {{(DataWidth-a09Pkg::absWidthP){1'b0}}, ir[a09Pkg::absWidthP-1:0]};

    // Offset is from the branch itself, PC already moved on by one
    assign branchTarget = relExt + pc - a09Pkg::word_t'(1);

    always_comb begin
        case (pcSrc)
            a09Pkg::pcBranch: nextPc = branchTarget;
            a09Pkg::pcStack:  nextPc = stack;
            a09Pkg::pcAbs:    nextPc = absExt;
            default:          nextPc = src1Data;   // Register-indirect, spare code
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcLd) begin
            pc <= nextPc;
        end else if (pcInc) begin
            pc <= pc + a09Pkg::word_t'(1);
        end
    end

    always_ff @(posedge Clk) begin
        if (stkLd) begin
            stack <= pc;            // Already points past the JPL
        end
    end

    aIncOrLoad: assert property (@(posedge Clk) disable iff (!rstN) !(pcInc && pcLd));

endmodule

`default_nettype wire

// File: design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile #(
    parameter int DataWidth = a09Pkg::dataWidthP
) (
    input  wire                   Clk,
    input  wire                   regWe,
    input  wire a09Pkg::dataSrc_t dataSrc,
    input  wire a09Pkg::word_t    ir,
    input  wire a09Pkg::word_t    memData,
    input  wire a09Pkg::word_t    aluResult,
    output a09Pkg::word_t         src1Data,
    output a09Pkg::word_t         src2Data
);

    a09Pkg::word_t   regs [2**a09Pkg::regSelWidthP];
    a09Pkg::opcode_t opcode;
    a09Pkg::regSel_t dstSel;        // IR[11:9]
    a09Pkg::regSel_t src1Sel;
    a09Pkg::regSel_t src2Sel;       // IR[6:4]
    a09Pkg::word_t   wrData;

    assign opcode  = a09Pkg::opcode_t'(ir[DataWidth-1 -: 4]);
    assign dstSel  = ir[11:9];
    assign src2Sel = ir[6:4];

    // OUT and ST name their register in the destination field
    assign src1Sel = (opcode == a09Pkg::opOut || opcode == a09Pkg::opSt) ? dstSel : ir[2:0];

    always_comb begin
        case (dataSrc)
            a09Pkg::dataImm: wrData = {{(DataWidth-a09Pkg::absWidthP){1'b0}},
                                       ir[a09Pkg::absWidthP-1:0]};
            a09Pkg::dataMem: wrData = memData;
            default:         wrData = aluResult;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (regWe) begin
            regs[dstSel] <= wrData;
        end
    end

    assign src1Data = regs[src1Sel];
    assign src2Data = regs[src2Sel];

endmodule

`default_nettype wire

// File: sequenceControl/sequenceControl.sv
`timescale 1ns/1ps
`default_nettype none

module sequenceControl #(
    parameter int DataWidth = a09Pkg::dataWidthP,
    parameter int AddrWidth = a09Pkg::addrWidthP
) (
    input  wire                 Clk,
    input  wire                 rstN,
    input  wire a09Pkg::word_t  memData,
    input  wire a09Pkg::flags_t flags,
    output a09Pkg::word_t       ir,
    output logic                irLd,
    output logic                memEn,
    output logic                memWr,
    output a09Pkg::addrSrc_t    addrSrc,
    output logic                pcInc,
    output logic                pcLd,
    output a09Pkg::pcSrc_t      pcSrc,
    output logic                stkLd,
    output logic                regWe,
    output a09Pkg::dataSrc_t    dataSrc,
    output a09Pkg::aluOp_t      aluOp,
    output logic                aluLd,
    output logic                flgLd,
    output logic                outLd,
    output logic                ready,
    output logic                halt
);

    a09Pkg::seqState_t state;
    a09Pkg::seqState_t nextState;
    a09Pkg::opcode_t   opcode;

    assign opcode = a09Pkg::opcode_t'(ir[DataWidth-1 -: 4]);   // Top nibble

    assign ready = (state != a09Pkg::sReset) && (state != a09Pkg::sHalt);
    assign halt  = (state == a09Pkg::sHalt);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= a09Pkg::sReset;
        end else begin
            state <= nextState;
        end
    end

    // Instruction register, fed straight from RAM read data
    always_ff @(posedge Clk) begin
        if (irLd) begin
            ir <= memData;
        end
    end

    // ALU function from opcode, only sampled when aluLd is up
    always_comb begin
        case (opcode)
            a09Pkg::opAdd: aluOp = a09Pkg::aluAdd;
            a09Pkg::opSub: aluOp = a09Pkg::aluSub;
            a09Pkg::opAnd: aluOp = a09Pkg::aluAnd;
            a09Pkg::opOr:  aluOp = a09Pkg::aluOr;
            default:       aluOp = a09Pkg::aluPass;
        endcase
    end

    // ------------------------------------------------------------------------
    // Control matrix
    // ------------------------------------------------------------------------
    always_comb begin
        nextState = state;
        irLd      = 1'b0;
        memEn     = 1'b0;
        memWr     = 1'b0;
        addrSrc   = a09Pkg::addrPc;
        pcInc     = 1'b0;
        pcLd      = 1'b0;
        pcSrc     = a09Pkg::pcBranch;
        stkLd     = 1'b0;
        regWe     = 1'b0;
        dataSrc   = a09Pkg::dataImm;
        aluLd     = 1'b0;
        flgLd     = 1'b0;
        outLd     = 1'b0;
        case (state)
            a09Pkg::sReset: nextState = a09Pkg::sFetch;
            a09Pkg::sFetch: begin
                memEn     = 1'b1;               // Read at PC
                nextState = a09Pkg::sDecode;
            end
            a09Pkg::sDecode: begin
                irLd      = 1'b1;
                pcInc     = 1'b1;               // PC now one past this instr
                nextState = a09Pkg::sExecute;
            end
            a09Pkg::sExecute: begin
                nextState = a09Pkg::sFetch;     // Most finish here
                case (opcode)
                    a09Pkg::opLdi: regWe = 1'b1;
                    a09Pkg::opLd: begin
                        memEn     = 1'b1;
                        addrSrc   = a09Pkg::addrAbs;
                        nextState = a09Pkg::sWriteback;
                    end
                    a09Pkg::opSt: begin
                        memEn   = 1'b1;
                        memWr   = 1'b1;
                        addrSrc = a09Pkg::addrAbs;
                    end
                    a09Pkg::opAdd, a09Pkg::opSub, a09Pkg::opAnd, a09Pkg::opOr: begin
                        aluLd     = 1'b1;
                        flgLd     = 1'b1;
                        nextState = a09Pkg::sWriteback;
                    end
                    a09Pkg::opOut: outLd = 1'b1;
                    a09Pkg::opBne: pcLd = !flags[a09Pkg::flagZeroP];  // Taken on Z clear
                    a09Pkg::opJpl: begin
                        pcLd  = 1'b1;
                        pcSrc = a09Pkg::pcAbs;
                        stkLd = 1'b1;           // Save return address
                    end
                    a09Pkg::opRet: begin
                        pcLd  = 1'b1;
                        pcSrc = a09Pkg::pcStack;
                    end
                    a09Pkg::opHlt: nextState = a09Pkg::sHalt;
                    default: ;                  // NOP and spare codes
                endcase
            end
            a09Pkg::sWriteback: begin
                regWe     = 1'b1;
                dataSrc   = (opcode == a09Pkg::opLd) ? a09Pkg::dataMem : a09Pkg::dataAlu;
                nextState = a09Pkg::sFetch;
            end
            a09Pkg::sHalt: nextState = a09Pkg::sHalt;   // Until reset
            default: nextState = a09Pkg::sReset;
        endcase
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    aStateLegal: assert property (@(posedge Clk) disable iff (!rstN)
        state inside {a09Pkg::sReset, a09Pkg::sFetch, a09Pkg::sDecode,
                      a09Pkg::sExecute, a09Pkg::sWriteback, a09Pkg::sHalt});

    aWrNotFetch: assert property (@(posedge Clk) disable iff (!rstN)
        !(memWr && irLd));

    aHaltQuiet: assert property (@(posedge Clk) disable iff (!rstN)
        halt |-> !regWe);

    // LD/ST address must land inside the RAM
    aAbsInRange: assert property (@(posedge Clk) disable iff (!rstN)
        (memEn && addrSrc == a09Pkg::addrAbs)
            |-> (ir[a09Pkg::absWidthP-1:0] < (1 << AddrWidth)));

endmodule

`default_nettype wire

// File: design/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter int DataWidth = a09Pkg::dataWidthP,
    parameter int AddrWidth = a09Pkg::addrWidthP
) (
    input  wire                 Clk,
    input  wire                 rstN,
    input  wire                 progWe,     // Program load, only under reset
    input  wire [AddrWidth-1:0] progAddr,
    input  wire a09Pkg::word_t  progData,
    output logic                ready,
    output logic                halt,
    output logic                irLd,
    output logic                memEn,
    output logic                outLd,
    output a09Pkg::word_t       irOut,
    output a09Pkg::word_t       outReg      // To the pins
);

    // ------------------------------------------------------------------------
    // Datapath nets
    // ------------------------------------------------------------------------
    a09Pkg::word_t    ir;
    a09Pkg::word_t    memData;
    a09Pkg::word_t    pc;
    a09Pkg::word_t    src1Data;   // ST data, OUT data, ALU A
    a09Pkg::word_t    src2Data;   // ALU B
    a09Pkg::word_t    aluResult;
    a09Pkg::flags_t   flags;

    // Control strobes
    logic             memWr;
    logic             pcInc;
    logic             pcLd;
    logic             stkLd;
    logic             regWe;
    logic             aluLd;
    logic             flgLd;
    a09Pkg::addrSrc_t addrSrc;
    a09Pkg::pcSrc_t   pcSrc;
    a09Pkg::dataSrc_t dataSrc;
    a09Pkg::aluOp_t   aluOp;

    assign irOut = ir;

    sequenceControl #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) seqCtrl (
        .Clk(Clk), .rstN(rstN),
        .memData(memData), .flags(flags), .ir(ir),
        .irLd(irLd), .memEn(memEn), .memWr(memWr), .addrSrc(addrSrc),
        .pcInc(pcInc), .pcLd(pcLd), .pcSrc(pcSrc), .stkLd(stkLd),
        .regWe(regWe), .dataSrc(dataSrc),
        .aluOp(aluOp), .aluLd(aluLd), .flgLd(flgLd),
        .outLd(outLd), .ready(ready), .halt(halt)
    );

    pcUnit #(.DataWidth(DataWidth)) pcBlock (
        .Clk(Clk), .rstN(rstN),
        .pcInc(pcInc), .pcLd(pcLd), .pcSrc(pcSrc), .stkLd(stkLd),
        .ir(ir), .src1Data(src1Data), .pc(pc)
    );

    registerFile #(.DataWidth(DataWidth)) regFile (
        .Clk(Clk), .regWe(regWe), .dataSrc(dataSrc), .ir(ir),
        .memData(memData), .aluResult(aluResult),
        .src1Data(src1Data), .src2Data(src2Data)
    );

    alu #(.DataWidth(DataWidth)) aluBlock (
        .Clk(Clk), .rstN(rstN),
        .aluOp(aluOp), .aluLd(aluLd), .flgLd(flgLd),
        .a(src1Data), .b(src2Data), .result(aluResult), .flags(flags)
    );

    memory #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) mem (
        .Clk(Clk), .memEn(memEn), .memWr(memWr), .addrSrc(addrSrc),
        .pc(pc), .ir(ir), .wrData(src1Data),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .rdData(memData)
    );

    // Output register, OUT copies src1 here
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            outReg <= '0;
        end else if (outLd) begin
            outReg <= src1Data;     // Visible the edge after outLd
        end
    end

endmodule

`default_nettype wire

// File: verification/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int         AddrWidth    = 8;
    localparam int         HalfPeriod   = 20;       // 40 ns clock
    localparam int         ResetCycles  = 16;
    localparam int         ReadyTimeout = 4;
    localparam int         OutTimeout   = 100;      // Cycles allowed between two OUTs
    localparam int         HaltTimeout  = 100;
    localparam int         QuietCycles  = 50;
    localparam logic [8:0] dataAddr     = 9'h080;   // Well past the program image
    localparam logic [8:0] subAddr      = 9'd24;    // Subroutine entry

    logic                 Clk;
    logic                 rstN;
    logic                 progWe;
    logic [AddrWidth-1:0] progAddr;
    a09Pkg::word_t        progData;
    logic                 ready;
    logic                 halt;
    logic                 irLd;
    logic                 memEn;
    logic                 outLd;
    a09Pkg::word_t        irOut;
    a09Pkg::word_t        outReg;

    a09Pkg::word_t progTable[$];    // Program image, word per address
    a09Pkg::word_t expTable[$];     // outReg values in OUT order

    cpu #(.DataWidth(16), .AddrWidth(AddrWidth)) UUT (
        .Clk(Clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .ready(ready), .halt(halt), .irLd(irLd), .memEn(memEn), .outLd(outLd),
        .irOut(irOut), .outReg(outReg)
    );

    always #HalfPeriod Clk = ~Clk;

    // ------------------------------------------------------------------------
    // Instruction encoding
    // ------------------------------------------------------------------------
    function automatic a09Pkg::word_t encode(input logic [3:0] op, input logic [2:0] dst,
                                             input logic [8:0] low);
        encode = {op, dst, low};    // Opcode, IR[11:9], IR[8:0]
    endfunction

    // Source 2 in IR[6:4], source 1 in IR[2:0]
    function automatic logic [8:0] regPair(input logic [2:0] rs1, input logic [2:0] rs2);
        regPair = {2'b00, rs2, 1'b0, rs1};
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic waitReady();
        int n;
        for (n = 0; n < ReadyTimeout; n++) begin
            @(negedge Clk);
            if (ready) return;
        end
        failRun("ready never rose after reset release");
    endtask

    task automatic waitOutLd(input int idx);
        int n;
        for (n = 0; n < OutTimeout; n++) begin
            @(negedge Clk);
            if (outLd) return;
        end
        failRun($sformatf("timeout waiting for output number %0d", idx));
    endtask

    task automatic waitHalt();
        int n;
        for (n = 0; n < HaltTimeout; n++) begin
            @(negedge Clk);
            if (halt) return;
        end
        failRun("timeout waiting for halt after the last output");
    endtask

    // ------------------------------------------------------------------------
    // Program and expected outputs
    // ------------------------------------------------------------------------
    task automatic buildTables();
        logic [31:0]   r;
        logic [8:0]    immA;
        logic [8:0]    immB;
        logic [8:0]    count;
        logic [9:0]    loopOff;
        logic [8:0]    marker;
        logic [8:0]    after;
        a09Pkg::word_t a;
        a09Pkg::word_t b;
        r      = $urandom(32'h8658);        // Seeds the generator, first draw
        immA   = r[8:0];
        r      = $urandom;
        immB   = r[8:0];
        r      = $urandom;
        count  = 9'd3 + {7'd0, r[1:0]};    // 3 to 6 passes
        loopOff = 10'd17 - 10'd19;          // Loop top minus branch address
        marker = 9'h1A5;
        after  = 9'h0C3;
        a      = {7'd0, immA};
        b      = {7'd0, immB};

        progTable.push_back(encode(a09Pkg::opLdi, 3'd1, immA));                 // 0
        progTable.push_back(encode(a09Pkg::opOut, 3'd1, 9'd0));
        progTable.push_back(encode(a09Pkg::opLdi, 3'd2, immB));
        progTable.push_back(encode(a09Pkg::opAdd, 3'd3, regPair(3'd1, 3'd2)));
        progTable.push_back(encode(a09Pkg::opOut, 3'd3, 9'd0));                 // 4
        progTable.push_back(encode(a09Pkg::opSub, 3'd3, regPair(3'd1, 3'd2)));
        progTable.push_back(encode(a09Pkg::opOut, 3'd3, 9'd0));
        progTable.push_back(encode(a09Pkg::opAnd, 3'd3, regPair(3'd1, 3'd2)));
        progTable.push_back(encode(a09Pkg::opOut, 3'd3, 9'd0));                 // 8
        progTable.push_back(encode(a09Pkg::opOr,  3'd3, regPair(3'd1, 3'd2)));
        progTable.push_back(encode(a09Pkg::opOut, 3'd3, 9'd0));
        progTable.push_back(encode(a09Pkg::opSt,  3'd3, dataAddr));
        progTable.push_back(encode(a09Pkg::opLdi, 3'd3, 9'd0));                 // 12, clobber
        progTable.push_back(encode(a09Pkg::opLd,  3'd4, dataAddr));
        progTable.push_back(encode(a09Pkg::opOut, 3'd4, 9'd0));
        progTable.push_back(encode(a09Pkg::opLdi, 3'd5, count));
        progTable.push_back(encode(a09Pkg::opLdi, 3'd6, 9'd1));                 // 16
        progTable.push_back(encode(a09Pkg::opOut, 3'd5, 9'd0));                 // Loop top
        progTable.push_back(encode(a09Pkg::opSub, 3'd5, regPair(3'd5, 3'd6)));
        progTable.push_back(encode(a09Pkg::opBne, {2'b00, loopOff[9]}, loopOff[8:0]));
        progTable.push_back(encode(a09Pkg::opJpl, 3'd0, subAddr));              // 20
        progTable.push_back(encode(a09Pkg::opLdi, 3'd7, after));                // Return here
        progTable.push_back(encode(a09Pkg::opOut, 3'd7, 9'd0));
        progTable.push_back(encode(a09Pkg::opHlt, 3'd0, 9'd0));
        progTable.push_back(encode(a09Pkg::opLdi, 3'd7, marker));               // 24, subroutine
        progTable.push_back(encode(a09Pkg::opOut, 3'd7, 9'd0));
        progTable.push_back(encode(a09Pkg::opRet, 3'd0, 9'd0));

        expTable.push_back(a);
        expTable.push_back(a + b);          // 16-bit wrap
        expTable.push_back(a - b);
        expTable.push_back(a & b);
        expTable.push_back(a | b);
        expTable.push_back(a | b);          // Through ST and LD
        for (int i = int'(count); i >= 1; i--) begin
            expTable.push_back(a09Pkg::word_t'(i));
        end
        expTable.push_back({7'd0, marker});
        expTable.push_back({7'd0, after});
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin : mainSeq
        int i;
        Clk      = 1'b0;
        rstN     = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        buildTables();

        for (i = 0; i < progTable.size(); i++) begin   // Image goes in under reset
            @(negedge Clk);
            progWe   = 1'b1;
            progAddr = AddrWidth'(i);
            progData = progTable[i];
        end
        @(negedge Clk);
        progWe = 1'b0;
        repeat (ResetCycles - 1) @(negedge Clk);

        check("ready", ready, 0);
        check("halt", halt, 0);
        check("outLd", outLd, 0);
        check("irLd", irLd, 0);
        check("memEn", memEn, 0);
        check("outReg", outReg, 0);
        rstN = 1'b1;
        waitReady();

        // First fetch, decode and IR load
        check("memEn", memEn, 1);
        check("irLd", irLd, 0);
        @(negedge Clk);
        check("irLd", irLd, 1);
        check("memEn", memEn, 0);
        @(negedge Clk);
        check("irOut", irOut, progTable[0]);

        for (i = 0; i < expTable.size(); i++) begin
            waitOutLd(i);
            check("ready", ready, 1);
            check("irOut[15:12]", irOut[15:12], a09Pkg::opOut);  // OUT in execute
            check("memEn", memEn, 0);
            @(negedge Clk);                 // outReg follows one edge later
            check($sformatf("outReg[%0d]", i), outReg, expTable[i]);
        end

        waitHalt();
        check("ready", ready, 0);
        for (i = 0; i < QuietCycles; i++) begin   // Nothing more once halted
            @(negedge Clk);
            check("outLd", outLd, 0);
            check("memEn", memEn, 0);
            check("irLd", irLd, 0);
            check("halt", halt, 1);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
common/a09Pkg.sv
design/alu.sv
design/memory.sv
design/pcUnit.sv
design/registerFile.sv
sequenceControl/sequenceControl.sv
design/cpu.sv
verification/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpuTb -f vlog.f -o VcpuTb

# The pipe keeps going on a fatal stop so the log search decides
./obj_dir/VcpuTb | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "FAIL: run ended without a result line"
    exit 1
fi
echo "PASS"
